// File: Makefile
TOP = gx4000_video_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: dv/gx4000_video_tb.sv
`include "gx_settings.svh"

module gx4000_video_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import gx_video_pkg::*;

    localparam int DRIVE_DELAY = 2;
    localparam int DRAIN_LIMIT = 20;

    logic        clk_sys = 1'b0;
    logic        reset;
    logic        gx4000_mode;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data;
    logic        cpu_wr;
    logic [1:0]  r_in;
    logic [1:0]  g_in;
    logic [1:0]  b_in;
    logic        hblank;
    logic        vblank;
    logic [7:0]  sprite_pixel;
    logic        sprite_active;
    logic [7:0]  r_out;
    logic [7:0]  g_out;
    logic [7:0]  b_out;
    logic [7:0]  config_reg;

    // Shadow of what the CPU has written
    colour_t    ref_red [16];
    colour_t    ref_green [16];
    colour_t    ref_blue [16];
    logic [7:0] ref_mode;
    logic [7:0] ref_effect;
    logic       ref_odd;
    logic [7:0] ref_cfg_mode;
    logic       ref_cfg_pal;
    logic       ref_cfg_video;

    rgb_t       exp_q [$];
    logic [`GX_PIPE_DEPTH-1:0] in_flight = '0;   // Accepted pixels per stage
    logic       quant_check = 1'b0;
    int         errors = 0;
    int         seed = 51;
    string      test_name = "reset";

    gx4000_video gx4000_video_i (.*);

    always #20 clk_sys = ~clk_sys;

    // Expected output colour from the channel, mode and effect rules
    function automatic rgb_t expected_rgb(logic [1:0] r, logic [1:0] g, logic [1:0] b,
                                          logic [7:0] spr, logic act);
        int         c [3];
        int         gray;
        logic [7:0] mode_eff;
        rgb_t       res;
        if (act) begin
            c[0] = int'(ref_red[spr[3:0]]);
            c[1] = int'(ref_green[spr[3:0]]);
            c[2] = int'(ref_blue[spr[3:0]]);
        end else begin
            c[0] = int'(ref_red[{2'b00, r}]);
            c[1] = int'(ref_green[{2'b00, g}]);
            c[2] = int'(ref_blue[{2'b00, b}]);
        end
        mode_eff = (ref_cfg_mode[0] && ref_cfg_video) ? ref_mode : 8'h00;
        if (act) begin
            case (ref_effect)
                EFFECT_OUTLINE:   if (spr == 8'h00) c = '{255, 255, 255};
                EFFECT_SHADOW:    foreach (c[i]) c[i] = c[i] / 2;
                EFFECT_GLOW:      foreach (c[i]) c[i] = (c[i] + 128) / 2;
                EFFECT_INVERT:    foreach (c[i]) c[i] = 255 - c[i];
                EFFECT_GRAYSCALE: begin
                    gray = (c[0] + c[1] + c[2]) / 3;
                    c = '{gray, gray, gray};
                end
                default: ;
            endcase
        end else begin
            case (mode_eff)
                MODE_INTERLACED: if (ref_odd) c = '{0, 0, 0};
                MODE_SCANLINE:   if (ref_odd) foreach (c[i]) c[i] = c[i] / 2;
                MODE_SHADOW:     foreach (c[i]) c[i] = c[i] / 2;
                default: ;
            endcase
        end
        if (!(ref_cfg_mode[0] && ref_cfg_pal)) begin
            foreach (c[i]) c[i] = c[i] - (c[i] % 16);   // Sixteen levels
        end
        res.red   = 8'(c[0]);
        res.green = 8'(c[1]);
        res.blue  = 8'(c[2]);
        return res;
    endfunction

    task automatic check_rgb(string name, rgb_t exp, rgb_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %06h, actual %06h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_config(string name, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %02h, actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #DRIVE_DELAY;
    endtask

    task automatic track_write(logic [15:0] addr, logic [7:0] data);
        if (addr[15:8] == `GX_PAL_PAGE) begin
            case (addr[7:4])
                `GX_PAL_RED_BASE:   ref_red[addr[3:0]] = data;
                `GX_PAL_GREEN_BASE: ref_green[addr[3:0]] = data;
                `GX_PAL_BLUE_BASE:  ref_blue[addr[3:0]] = data;
                default: ;
            endcase
        end
        case (addr[7:0])
            `GX_ADDR_SCREEN_Y:       ref_odd = data[0];
            `GX_ADDR_VIDEO_MODE:     ref_mode = data;
            `GX_ADDR_SPRITE_EFFECT:  ref_effect = data;
            `GX_ADDR_CONFIG_MODE:    ref_cfg_mode = data;
            `GX_ADDR_CONFIG_PALETTE: ref_cfg_pal = data[0];
            `GX_ADDR_CONFIG_VIDEO:   ref_cfg_video = data[0];
            default: ;
        endcase
    endtask

    task automatic cpu_write(logic [15:0] addr, logic [7:0] data);
        cpu_addr = addr;
        cpu_data = data;
        cpu_wr   = 1'b1;
        if (gx4000_mode) track_write(addr, data);   // Ignored by the DUT otherwise
        next_cycle();
        cpu_wr = 1'b0;
    endtask

    task automatic write_ctrl(logic [7:0] addr, logic [7:0] data);
        cpu_write({8'h00, addr}, data);
    endtask

    task automatic drive_pixel(logic [1:0] r, logic [1:0] g, logic [1:0] b,
                               logic [7:0] spr, logic act);
        r_in          = r;
        g_in          = g;
        b_in          = b;
        sprite_pixel  = spr;
        sprite_active = act;
        hblank        = 1'b0;
        vblank        = 1'b0;
        if (gx4000_mode) exp_q.push_back(expected_rgb(r, g, b, spr, act));
        next_cycle();
    endtask

    task automatic random_pixel(logic act);
        int tmp;
        tmp = $random(seed);
        drive_pixel(tmp[1:0], tmp[3:2], tmp[5:4], tmp[15:8], act);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        hblank = 1'b1;
        while ((exp_q.size() != 0 || in_flight != '0) && cycles < DRAIN_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d pixels never reached the outputs",
                     test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // Inputs are stable at the edge, outputs are read mid-cycle
    always @(posedge clk_sys) begin
        in_flight = {in_flight[`GX_PIPE_DEPTH-2:0],
                     gx4000_mode && !hblank && !vblank && !reset};
    end

    always @(negedge clk_sys) begin
        if (in_flight[`GX_PIPE_DEPTH-1]) begin
            if (exp_q.size() == 0) begin
                $display("Output updated in %s with no pixel expected", test_name);
                errors++;
            end else begin
                check_rgb(test_name, exp_q.pop_front(), {r_out, g_out, b_out});
            end
            if (quant_check && ({r_out, g_out, b_out} & 24'h0F0F0F) != 24'h0) begin
                $display("Low nibble set on an output during %s", test_name);
                errors++;
            end
        end
    end

    initial begin
        rgb_t last;
        int   tmp;
        reset = 1'b1;
        gx4000_mode = 1'b1;
        cpu_addr = 16'h0000;
        cpu_data = 8'h00;
        cpu_wr = 1'b0;
        r_in = 2'b00;
        g_in = 2'b00;
        b_in = 2'b00;
        hblank = 1'b1;
        vblank = 1'b0;
        sprite_pixel = 8'h00;
        sprite_active = 1'b0;
        for (int i = 0; i < 16; i++) begin
            ref_red[i]   = 8'h00;
            ref_green[i] = 8'h00;
            ref_blue[i]  = 8'h00;
        end
        ref_mode = 8'h00;
        ref_effect = 8'h00;
        ref_odd = 1'b0;
        ref_cfg_mode = 8'h00;
        ref_cfg_pal = 1'b0;
        ref_cfg_video = 1'b0;
        repeat (3) @(posedge clk_sys);
        #DRIVE_DELAY reset = 1'b0;

        check_rgb("reset_outputs", 24'h000000, {r_out, g_out, b_out});
        check_config("reset_config", 8'h00, config_reg);
        test_name = "config";
        write_ctrl(`GX_ADDR_CONFIG_MODE, 8'h01);
        check_config("config_write", 8'h01, config_reg);
        gx4000_mode = 1'b0;
        write_ctrl(`GX_ADDR_CONFIG_MODE, 8'hA6);
        cpu_write({`GX_PAL_PAGE, `GX_PAL_RED_BASE, 4'h3}, 8'h5A);   // Must not land
        check_config("config_mode_low", 8'h01, config_reg);
        gx4000_mode = 1'b1;
        drive_pixel(2'b11, 2'b00, 2'b00, 8'h00, 1'b0);   // Red entry 3 still zero
        wait_drain();

        test_name = "palette";
        write_ctrl(`GX_ADDR_CONFIG_PALETTE, 8'h01);
        for (int i = 0; i < 16; i++) begin
            tmp = $random(seed);
            cpu_write({`GX_PAL_PAGE, `GX_PAL_RED_BASE, 4'(i)}, tmp[7:0]);
            cpu_write({`GX_PAL_PAGE, `GX_PAL_GREEN_BASE, 4'(i)}, tmp[15:8]);
            cpu_write({`GX_PAL_PAGE, `GX_PAL_BLUE_BASE, 4'(i)}, tmp[23:16]);
        end
        repeat (200) random_pixel(1'b0);
        wait_drain();

        test_name = "video_modes";
        write_ctrl(`GX_ADDR_CONFIG_VIDEO, 8'h01);
        for (int m = 3; m <= 5; m++) begin
            write_ctrl(`GX_ADDR_VIDEO_MODE, 8'(m));
            for (int odd = 0; odd < 2; odd++) begin
                write_ctrl(`GX_ADDR_SCREEN_Y, 8'(odd));
                repeat (20) random_pixel(1'b0);
                wait_drain();
            end
        end
        write_ctrl(`GX_ADDR_CONFIG_VIDEO, 8'h00);   // Mode stays 5 but has no effect
        repeat (20) random_pixel(1'b0);
        wait_drain();

        test_name = "sprite_effects";
        for (int e = 0; e < 6; e++) begin
            write_ctrl(`GX_ADDR_SPRITE_EFFECT, 8'(e));
            drive_pixel(2'b00, 2'b00, 2'b00, 8'h00, 1'b1);
            repeat (24) random_pixel(1'b1);
            wait_drain();
        end

        test_name = "quantise";
        quant_check = 1'b1;
        write_ctrl(`GX_ADDR_CONFIG_MODE, 8'h00);
        repeat (30) random_pixel(1'($random(seed)));
        wait_drain();
        write_ctrl(`GX_ADDR_CONFIG_MODE, 8'h01);
        write_ctrl(`GX_ADDR_CONFIG_PALETTE, 8'h00);
        repeat (30) random_pixel(1'($random(seed)));
        wait_drain();
        quant_check = 1'b0;

        test_name = "blank_hold";
        last = expected_rgb(2'b01, 2'b10, 2'b11, 8'h00, 1'b0);
        drive_pixel(2'b01, 2'b10, 2'b11, 8'h00, 1'b0);
        wait_drain();
        for (int i = 0; i < 20; i++) begin
            tmp = $random(seed);
            r_in   = tmp[1:0];
            g_in   = tmp[3:2];
            b_in   = tmp[5:4];
            hblank = (i < 10);
            vblank = (i >= 10);
            next_cycle();
            check_rgb(test_name, last, {r_out, g_out, b_out});
        end
        wait_drain();

        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/gx4000_video.sv
module gx4000_video (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        gx4000_mode,

    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_data,
    input  logic        cpu_wr,

    input  logic [1:0]  r_in,
    input  logic [1:0]  g_in,
    input  logic [1:0]  b_in,
    input  logic        hblank,
    input  logic        vblank,

    input  logic [7:0]  sprite_pixel,
    input  logic        sprite_active,

    output logic [7:0]  r_out,
    output logic [7:0]  g_out,
    output logic [7:0]  b_out,
    output logic [7:0]  config_reg
);
    import gx_video_pkg::*;

    pixel_t pixel;
    logic   pixel_valid;
    rgb_t   rgb;

    gx_palette_wr_if pal_wr_if ();
    gx_video_ctrl_if video_ctrl_if ();

    gx_register_file gx_register_file_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .cpu_wr      (cpu_wr),
        .pal         (pal_wr_if),
        .ctrl        (video_ctrl_if),
        .config_reg  (config_reg)
    );

    // Stage 1, palette lookup
    gx_colour_lookup gx_colour_lookup_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .gx4000_mode   (gx4000_mode),
        .pal           (pal_wr_if),
        .r_in          (r_in),
        .g_in          (g_in),
        .b_in          (b_in),
        .hblank        (hblank),
        .vblank        (vblank),
        .sprite_pixel  (sprite_pixel),
        .sprite_active (sprite_active),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid)
    );

    // Stage 2, mode and effect
    gx_pixel_effects gx_pixel_effects_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .ctrl        (video_ctrl_if),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .rgb         (rgb)
    );

    assign r_out = rgb.red;
    assign g_out = rgb.green;
    assign b_out = rgb.blue;

endmodule

// File: hdl/gx_colour_lookup.sv
`include "gx_settings.svh"

module gx_colour_lookup (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 gx4000_mode,
    gx_palette_wr_if.sink        pal,
    input  logic [1:0]           r_in,
    input  logic [1:0]           g_in,
    input  logic [1:0]           b_in,
    input  logic                 hblank,
    input  logic                 vblank,
    input  logic [7:0]           sprite_pixel,
    input  logic                 sprite_active,
    output gx_video_pkg::pixel_t pixel,
    output logic                 pixel_valid
);
    import gx_video_pkg::*;

    // One plane per channel
    colour_t    palette [3][`GX_PAL_ENTRIES];
    pal_index_t red_idx;
    pal_index_t green_idx;
    pal_index_t blue_idx;
    logic       accept;

    assign accept = gx4000_mode && !hblank && !vblank;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int ch = 0; ch < 3; ch++) begin
                for (int i = 0; i < `GX_PAL_ENTRIES; i++) begin
                    palette[ch][i] <= 8'h00;
                end
            end
        end else if (pal.wr && (pal.channel inside {CH_RED, CH_GREEN, CH_BLUE})) begin
            palette[pal.channel][pal.index] <= pal.data;
        end
    end

    // Sprite code drives all three planes
    always_comb begin
        if (sprite_active) begin
            red_idx   = sprite_pixel[3:0];
            green_idx = sprite_pixel[3:0];
            blue_idx  = sprite_pixel[3:0];
        end else begin
            red_idx   = {2'b00, r_in};
            green_idx = {2'b00, g_in};
            blue_idx  = {2'b00, b_in};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= accept;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            pixel.colour.red   <= palette[CH_RED][red_idx];
            pixel.colour.green <= palette[CH_GREEN][green_idx];
            pixel.colour.blue  <= palette[CH_BLUE][blue_idx];
            pixel.is_sprite    <= sprite_active;
            pixel.blank_sprite <= sprite_active && (sprite_pixel == 8'h00);
        end
    end

    a_no_valid_after_blank: assert property (@(posedge clk_sys) disable iff (reset)
        (hblank || vblank) |=> !pixel_valid);

endmodule

// File: hdl/gx_pixel_effects.sv
`include "gx_settings.svh"

module gx_pixel_effects (
    input  logic                 clk_sys,
    input  logic                 reset,
    gx_video_ctrl_if.sink        ctrl,
    input  gx_video_pkg::pixel_t pixel,
    input  logic                 pixel_valid,
    output gx_video_pkg::rgb_t   rgb
);
    import gx_video_pkg::*;

    rgb_t       moded;
    rgb_t       quantised;
    logic [9:0] gray_sum;
    colour_t    gray;

    function automatic rgb_t halve(rgb_t c);
        return '{c.red >> 1, c.green >> 1, c.blue >> 1};
    endfunction

    // Midway towards white, sum kept at 9 bits
    function automatic colour_t glow(colour_t c);
        logic [8:0] sum;
        sum = {1'b0, c} + 9'd128;
        return sum[8:1];
    endfunction

    always_comb begin
        moded    = pixel.colour;
        gray_sum = 10'(pixel.colour.red) + 10'(pixel.colour.green) +
                   10'(pixel.colour.blue);
        gray     = colour_t'(gray_sum / 10'd3);    // Max 765 / 3 fits in a byte

        if (pixel.is_sprite) begin
            case (ctrl.effect)
                EFFECT_OUTLINE: begin
                    if (pixel.blank_sprite) begin
                        moded = '{8'hFF, 8'hFF, 8'hFF};
                    end
                end
                EFFECT_SHADOW:    moded = halve(pixel.colour);
                EFFECT_GLOW: begin
                    moded = '{glow(pixel.colour.red), glow(pixel.colour.green),
                              glow(pixel.colour.blue)};
                end
                EFFECT_INVERT:    moded = ~pixel.colour;
                EFFECT_GRAYSCALE: moded = '{gray, gray, gray};
                default:          ;
            endcase
        end else begin
            case (ctrl.mode)
                MODE_INTERLACED: begin
                    if (ctrl.odd_line) begin
                        moded = '0;    // Odd lines dark
                    end
                end
                MODE_SCANLINE: begin
                    if (ctrl.odd_line) begin
                        moded = halve(pixel.colour);
                    end
                end
                MODE_SHADOW: moded = halve(pixel.colour);
                default:     ;
            endcase
        end

        quantised = ctrl.quantise ? (moded & {3{`GX_QUANT_MASK}}) : moded;
    end

    // Outputs hold between valid pixels
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rgb <= '0;
        end else if (pixel_valid) begin
            rgb <= quantised;
        end
    end

endmodule

// File: hdl/gx_register_file.sv
`include "gx_settings.svh"

module gx_register_file (
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            gx4000_mode,
    input  logic [15:0]     cpu_addr,
    input  logic [7:0]      cpu_data,
    input  logic            cpu_wr,
    gx_palette_wr_if.source pal,
    gx_video_ctrl_if.source ctrl,
    output logic [7:0]      config_reg
);
    import gx_video_pkg::*;

    logic       wr_en;
    logic       plane_hit;
    channel_e   plane;
    logic       odd_line_q;
    logic [7:0] video_mode_q;
    logic [7:0] sprite_effect_q;
    logic [7:0] config_mode_q;
    logic       pal32_en_q;      // config_palette bit 0
    logic       video_fx_en_q;   // config_video bit 0

    assign wr_en = cpu_wr && gx4000_mode;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            odd_line_q      <= 1'b0;
            video_mode_q    <= 8'h00;
            sprite_effect_q <= 8'h00;
            config_mode_q   <= 8'h00;
            pal32_en_q      <= 1'b0;
            video_fx_en_q   <= 1'b0;
        end else if (wr_en) begin
            case (cpu_addr[7:0])
                `GX_ADDR_SCREEN_X:       ;    // Position has no bearing on colour
                `GX_ADDR_SCREEN_Y:       odd_line_q <= cpu_data[0];
                `GX_ADDR_VIDEO_MODE:     video_mode_q <= cpu_data;
                `GX_ADDR_SPRITE_EFFECT:  sprite_effect_q <= cpu_data;
                `GX_ADDR_CONFIG_MODE:    config_mode_q <= cpu_data;
                `GX_ADDR_CONFIG_PALETTE: pal32_en_q <= cpu_data[0];
                `GX_ADDR_CONFIG_VIDEO:   video_fx_en_q <= cpu_data[0];
                default:                 ;
            endcase
        end
    end

    // Palette plane from address bits 7:4
    always_comb begin
        plane_hit = 1'b1;
        plane     = CH_RED;
        case (cpu_addr[7:4])
            `GX_PAL_RED_BASE:   plane = CH_RED;
            `GX_PAL_GREEN_BASE: plane = CH_GREEN;
            `GX_PAL_BLUE_BASE:  plane = CH_BLUE;
            default:            plane_hit = 1'b0;
        endcase
    end

    // Written on the same edge so the lookup sees it one edge later
    assign pal.wr      = wr_en && (cpu_addr[15:8] == `GX_PAL_PAGE) && plane_hit;
    assign pal.channel = plane;
    assign pal.index   = pal_index_t'(cpu_addr[3:0]);
    assign pal.data    = cpu_data;

    assign ctrl.mode     = (config_mode_q[0] && video_fx_en_q) ?
                           video_mode_e'(video_mode_q) : MODE_NORMAL;
    assign ctrl.effect   = sprite_effect_e'(sprite_effect_q);
    assign ctrl.odd_line = odd_line_q;
    assign ctrl.quantise = !(config_mode_q[0] && pal32_en_q);    // 16 levels unless 32-colour

    assign config_reg = config_mode_q;

    // Palette bytes and control registers sit at separate addresses
    a_pal_wr_keeps_ctrl: assert property (@(posedge clk_sys) disable iff (reset)
        pal.wr |=> ($stable(config_reg) && $stable(ctrl.mode) && $stable(ctrl.effect)
                    && $stable(ctrl.odd_line) && $stable(ctrl.quantise)));

    a_config_stable: assert property (@(posedge clk_sys) disable iff (reset)
        !(wr_en && cpu_addr[7:0] == `GX_ADDR_CONFIG_MODE) |=> $stable(config_reg));

endmodule

// File: hdl/gx_video_ifs.sv
// Palette byte write, one cycle strobe
interface gx_palette_wr_if;
    import gx_video_pkg::*;

    logic       wr;
    channel_e   channel;
    pal_index_t index;
    colour_t    data;

    modport source (output wr, channel, index, data);
    modport sink   (input  wr, channel, index, data);
endinterface

// Settled control levels for the effects stage
interface gx_video_ctrl_if;
    import gx_video_pkg::*;

    video_mode_e    mode;       // Already forced to normal when disabled
    sprite_effect_e effect;
    logic           odd_line;
    logic           quantise;

    modport source (output mode, effect, odd_line, quantise);
    modport sink   (input  mode, effect, odd_line, quantise);
endinterface

// File: hdl/gx_video_pkg.sv
package gx_video_pkg;

    typedef logic [7:0] colour_t;    // One channel

    typedef struct packed {
        colour_t red;
        colour_t green;
        colour_t blue;
    } rgb_t;

    typedef logic [3:0] pal_index_t;

    // Palette plane targeted by a CPU write
    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
    } channel_e;

    // Unlisted codes fall back to normal
    typedef enum logic [7:0] {
        MODE_NORMAL     = 8'h00,
        MODE_INTERLACED = 8'h03,
        MODE_SCANLINE   = 8'h04,
        MODE_SHADOW     = 8'h05
    } video_mode_e;

    // Unlisted codes fall back to none
    typedef enum logic [7:0] {
        EFFECT_NONE      = 8'h00,
        EFFECT_OUTLINE   = 8'h01,
        EFFECT_SHADOW    = 8'h02,
        EFFECT_GLOW      = 8'h03,
        EFFECT_INVERT    = 8'h04,
        EFFECT_GRAYSCALE = 8'h05
    } sprite_effect_e;

    typedef struct packed {
        rgb_t colour;
        logic is_sprite;
        logic blank_sprite;    // Sprite code was zero
    } pixel_t;

endpackage

// File: include/gx_settings.svh
`ifndef GX_SETTINGS_SVH
`define GX_SETTINGS_SVH

// Control registers, decoded from the low address byte only
`define GX_ADDR_SCREEN_X        8'h80
`define GX_ADDR_SCREEN_Y        8'h81
`define GX_ADDR_VIDEO_MODE      8'h82
`define GX_ADDR_SPRITE_EFFECT   8'h8D
`define GX_ADDR_CONFIG_MODE     8'h90
`define GX_ADDR_CONFIG_PALETTE  8'h91
`define GX_ADDR_CONFIG_VIDEO    8'h93

// Upper address byte of all palette writes
`define GX_PAL_PAGE             8'h7F

// Plane select in address bits 7:4, entry in bits 3:0
`define GX_PAL_RED_BASE         4'h6
`define GX_PAL_GREEN_BASE       4'h7
`define GX_PAL_BLUE_BASE        4'h5

`define GX_PAL_ENTRIES          16

// Sixteen levels per channel
`define GX_QUANT_MASK           8'hF0

// Accept edge to output edge
`define GX_PIPE_DEPTH           2

`endif

// File: tb.f
+incdir+include
hdl/gx_video_pkg.sv
hdl/gx_video_ifs.sv
hdl/gx_register_file.sv
hdl/gx_colour_lookup.sv
hdl/gx_pixel_effects.sv
hdl/gx4000_video.sv
dv/gx4000_video_tb.sv
